// ==== hdl/dbg_cpu_params.svh ====
`ifndef DBG_CPU_PARAMS_SVH
`define DBG_CPU_PARAMS_SVH

// TAP data register layout
`define DBG_DR_W        53
// Top-level flag, 0 means the command is ours
`define DBG_CMD_BIT     52
`define DBG_OP_HI       51
`define DBG_OP_LO       48
`define DBG_ADDR_HI     47
`define DBG_ADDR_LO     16
// Word count sits in bits 15..0
`define DBG_CNT_W       16

// SPR bus word and address width
`define DBG_WORD_W      32
`define DBG_BITCNT_W    6
// Register select lives at the top of the address field
`define DBG_REGSEL_W    1

// Reflected CRC-32 polynomial
`define DBG_CRC_POLY    32'hEDB88320

// Command opcodes
`define DBG_OP_BWRITE32 4'h3
`define DBG_OP_BREAD32  4'h7
`define DBG_OP_IREG_WR  4'h9
`define DBG_OP_IREG_SEL 4'hd

`endif

// ==== hdl/dbg_cpu_pkg.sv ====
`include "dbg_cpu_params.svh"

package dbg_cpu_pkg;

  // Burst FSM states
  typedef enum logic [3:0] {
    st_idle    = 4'h0,
    st_rbegin  = 4'h1,  // First read strobe
    st_rready  = 4'h2,  // Wait for capture
    st_rstatus = 4'h3,  // Host polls ready bit
    st_rburst  = 4'h4,
    st_rcrc    = 4'h5,
    st_wready  = 4'h6,
    st_wwait   = 4'h7,  // Wait for start bit
    st_wburst  = 4'h8,
    st_wcrc    = 4'h9,
    st_wmatch  = 4'ha   // Match bit on TDO until update
  } dbg_state_e;

  // Opcodes this module acts on
  typedef enum logic [3:0] {
    op_bwrite32 = `DBG_OP_BWRITE32,
    op_bread32  = `DBG_OP_BREAD32,
    op_ireg_wr  = `DBG_OP_IREG_WR,
    op_ireg_sel = `DBG_OP_IREG_SEL
  } dbg_op_e;

endpackage

// ==== hdl/dbg_cpu_bus_if.sv ====
`timescale 1ns/1ps
`include "dbg_cpu_params.svh"

// Access request from burst control to the SPR bridge
interface dbg_cpu_bus_if;

  logic                   strobe;  // One cycle, always accepted
  logic                   rd_wrn;  // 1 = read
  logic [`DBG_WORD_W-1:0] addr;
  logic [`DBG_WORD_W-1:0] wdata;
  logic [`DBG_WORD_W-1:0] rdata;   // Valid while rdy is high
  logic                   rdy;     // Low from strobe until ack is done

  modport ctrl (
    output strobe,
    output rd_wrn,
    output addr,
    output wdata,
    input  rdata,
    input  rdy
  );

  modport bridge (
    input  strobe,
    input  rd_wrn,
    input  addr,
    input  wdata,
    output rdata,
    output rdy
  );

endinterface

// ==== hdl/dbg_cpu_spr_bridge.sv ====
`timescale 1ns/1ps
`include "dbg_cpu_params.svh"

module dbg_cpu_spr_bridge (
  input  logic                   tck_i,
  input  logic                   rst_i,
  dbg_cpu_bus_if.bridge          bus_if,
  output logic [`DBG_WORD_W-1:0] cpu_addr_o,
  output logic [`DBG_WORD_W-1:0] cpu_data_o,
  input  logic [`DBG_WORD_W-1:0] cpu_data_i,
  output logic                   cpu_stb_o,
  output logic                   cpu_we_o,
  input  logic                   cpu_ack_i
);

  logic                   stb_q;     // Access in flight on the SPR bus
  logic                   rd_wrn_q;
  logic                   rdy_q;
  logic                   ack_seen;
  logic [`DBG_WORD_W-1:0] addr_q;
  logic [`DBG_WORD_W-1:0] wdata_q;
  logic [`DBG_WORD_W-1:0] rdata_q;

  assign ack_seen = stb_q & cpu_ack_i;

  // Handshake state
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stb_q    <= 1'b0;
      rd_wrn_q <= 1'b1;
      rdy_q    <= 1'b1;  // Idle bridge reports ready
    end else if (bus_if.strobe) begin
      stb_q    <= 1'b1;  // Bus strobe follows one cycle later
      rd_wrn_q <= bus_if.rd_wrn;
      rdy_q    <= 1'b0;
    end else if (ack_seen) begin
      stb_q <= 1'b0;
      rdy_q <= 1'b1;     // Rises the cycle after ack
    end
  end

  // Request and response payload
  always_ff @(posedge tck_i) begin
    if (bus_if.strobe) begin
      addr_q  <= bus_if.addr;
      wdata_q <= bus_if.wdata;
    end
    if (ack_seen && rd_wrn_q) begin
      rdata_q <= cpu_data_i;  // Read data only on a read ack
    end
  end

  assign cpu_addr_o   = addr_q;
  assign cpu_data_o   = wdata_q;
  assign cpu_stb_o    = stb_q;
  assign cpu_we_o     = stb_q & ~rd_wrn_q;  // Write enable only qualified by strobe
  assign bus_if.rdata = rdata_q;
  assign bus_if.rdy   = rdy_q;

endmodule

// ==== hdl/dbg_cpu_crc32.sv ====
`timescale 1ns/1ps
`include "dbg_cpu_params.svh"

// Bit-serial reflected CRC-32, also its own output shifter
module dbg_cpu_crc32 (
  input  logic                   tck_i,
  input  logic                   rst_i,
  input  logic                   data_i,
  input  logic                   enable_i,  // Fold one bit in
  input  logic                   shift_i,   // Shift out, LSB first
  input  logic                   clr_i,
  output logic [`DBG_WORD_W-1:0] crc_o,
  output logic                   serial_o
);

  logic [`DBG_WORD_W-1:0] crc_q;
  logic                   feedback;

  assign feedback = crc_q[0] ^ data_i;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= '1;
    end else if (clr_i) begin
      crc_q <= '1;  // Seed for a new burst
    end else if (enable_i) begin
      crc_q <= {1'b0, crc_q[`DBG_WORD_W-1:1]} ^ (feedback ? `DBG_CRC_POLY : '0);
    end else if (shift_i) begin
      crc_q <= {1'b0, crc_q[`DBG_WORD_W-1:1]};
    end
  end

  // No final inversion
  assign crc_o    = crc_q;
  assign serial_o = crc_q[0];

endmodule

// ==== hdl/dbg_cpu_status_reg.sv ====
`timescale 1ns/1ps

// CPU stall and reset controls
module dbg_cpu_status_reg (
  input  logic       tck_i,
  input  logic       rst_i,
  input  logic       we_i,
  input  logic [1:0] data_i,      // {reset, stall}
  input  logic       bp_i,        // Breakpoint from the CPU
  output logic [1:0] ctrl_reg_o,
  output logic       cpu_stall_o,
  output logic       cpu_rst_o
);

  logic [1:0] ctrl_q;
  logic       bp_q;
  logic       bp_rise;

  assign bp_rise = bp_i & ~bp_q;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      ctrl_q <= 2'b00;
      bp_q   <= 1'b0;
    end else begin
      bp_q <= bp_i;
      if (we_i) begin
        ctrl_q <= data_i;
      end
      // Breakpoint wins over a write in the same cycle
      if (bp_rise) begin
        ctrl_q[0] <= 1'b1;
      end
    end
  end

  assign ctrl_reg_o  = ctrl_q;
  assign cpu_stall_o = ctrl_q[0] | bp_i;  // Stall at once, before the bit is set
  assign cpu_rst_o   = ctrl_q[1];

endmodule

// ==== hdl/dbg_cpu_burst_ctrl.sv ====
`timescale 1ns/1ps
`include "dbg_cpu_params.svh"

module dbg_cpu_burst_ctrl
  import dbg_cpu_pkg::*;
(
  input  logic                   tck_i,
  input  logic                   rst_i,
  input  logic                   tdi_i,
  input  logic                   capture_dr_i,
  input  logic                   shift_dr_i,
  input  logic                   update_dr_i,
  input  logic                   module_select_i,
  input  logic [`DBG_DR_W-1:0]   data_register_i,
  dbg_cpu_bus_if.ctrl            bus_if,
  input  logic [`DBG_WORD_W-1:0] crc_o,
  input  logic                   crc_serial_i,
  output logic                   crc_data_o,
  output logic                   crc_en_o,
  output logic                   crc_shift_o,
  output logic                   crc_clr_o,
  input  logic [1:0]             status_i,
  output logic                   status_we_o,
  output logic                   module_tdo_o,
  output logic                   top_inhibit_o
);

  localparam logic [`DBG_BITCNT_W-1:0] bit_last = `DBG_WORD_W - 1;
  localparam logic [`DBG_BITCNT_W-1:0] bit_crc_end = `DBG_WORD_W;

  dbg_state_e               state_q, state_d;
  dbg_op_e                  op_in, operation_q;
  logic [`DBG_WORD_W-1:0]   addr_q;
  logic [`DBG_WORD_W-1:0]   shift_q;
  logic [`DBG_WORD_W-1:0]   intreg_data;
  logic [`DBG_CNT_W-1:0]    word_cnt_q;
  logic [`DBG_CNT_W-1:0]    word_cnt_dec;
  logic [`DBG_BITCNT_W-1:0] bit_cnt_q;
  logic [`DBG_REGSEL_W-1:0] regsel_q, regsel_in;
  logic                     module_cmd, burst_cmd, intreg_cmd, rd_op;
  logic                     word_zero, bit_max, bit_32, crc_match;
  // FSM outputs
  logic                     addr_ld, addr_inc, op_ld, regsel_ld;
  logic                     bit_en, bit_rst, word_ld, word_dec;
  logic                     out_ld, out_sel_bus, out_shift, strobe;
  logic [1:0]               tdo_sel;  // 0 rdy, 1 shift reg, 2 CRC match, 3 CRC out

  ////////////////////////////////////////////////////////////////////////////
  // Command decode, taken straight from the data register

  assign module_cmd = ~data_register_i[`DBG_CMD_BIT];
  assign op_in      = dbg_op_e'(data_register_i[`DBG_OP_HI:`DBG_OP_LO]);
  assign regsel_in  = data_register_i[`DBG_ADDR_HI -: `DBG_REGSEL_W];
  assign burst_cmd  = module_cmd & (op_in == op_bwrite32 || op_in == op_bread32);
  assign intreg_cmd = module_cmd & (op_in == op_ireg_wr || op_in == op_ireg_sel);
  assign rd_op      = (operation_q == op_bread32);

  assign word_cnt_dec = word_cnt_q - 1'b1;
  assign word_zero    = (word_cnt_q == '0);
  assign bit_max      = (bit_cnt_q == bit_last);
  assign bit_32       = (bit_cnt_q == bit_crc_end);  // All 32 CRC bits are in

  ////////////////////////////////////////////////////////////////////////////
  // Counters and registers

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q     <= st_idle;
      operation_q <= op_bwrite32;
      regsel_q    <= '0;
      bit_cnt_q   <= '0;
      word_cnt_q  <= '0;
    end else begin
      state_q <= state_d;
      if (op_ld) operation_q <= op_in;
      if (regsel_ld) regsel_q <= regsel_in;
      if (bit_rst) begin
        bit_cnt_q <= '0;
      end else if (bit_en) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      if (word_ld) begin
        word_cnt_q <= data_register_i[`DBG_CNT_W-1:0];
      end else if (word_dec) begin
        word_cnt_q <= word_cnt_dec;
      end
    end
  end

  // SPR addresses count in words
  always_ff @(posedge tck_i) begin
    if (addr_ld) begin
      addr_q <= data_register_i[`DBG_ADDR_HI:`DBG_ADDR_LO];
    end else if (addr_inc) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  // Only the status register exists, other selects read zero
  assign intreg_data = (regsel_q == '0) ? {{(`DBG_WORD_W-2){1'b0}}, status_i} : '0;

  // Output shift register, load beats shift
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      shift_q <= '0;
    end else if (out_ld) begin
      shift_q <= out_sel_bus ? bus_if.rdata : intreg_data;
    end else if (out_shift) begin
      shift_q <= {1'b0, shift_q[`DBG_WORD_W-1:1]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus request, CRC feed and TDO

  assign bus_if.strobe = strobe;
  assign bus_if.rd_wrn = rd_op;
  assign bus_if.addr   = addr_q;
  // tdi_i is one bit ahead of the data register
  assign bus_if.wdata  = {tdi_i, data_register_i[`DBG_DR_W-1 -: `DBG_WORD_W-1]};

  assign crc_data_o = rd_op ? shift_q[0] : tdi_i;
  assign crc_match  = (data_register_i[`DBG_DR_W-1 -: `DBG_WORD_W] == crc_o);

  always_comb begin
    case (tdo_sel)
      2'd0:    module_tdo_o = bus_if.rdy;
      2'd1:    module_tdo_o = shift_q[0];
      2'd2:    module_tdo_o = crc_match;
      default: module_tdo_o = crc_serial_i;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Burst FSM

  always_comb begin
    state_d       = state_q;
    addr_ld       = 1'b0;
    addr_inc      = 1'b0;
    op_ld         = 1'b0;
    regsel_ld     = 1'b0;
    bit_en        = 1'b0;
    bit_rst       = 1'b0;
    word_ld       = 1'b0;
    word_dec      = 1'b0;
    out_ld        = 1'b0;
    out_sel_bus   = 1'b0;
    out_shift     = 1'b0;
    strobe        = 1'b0;
    tdo_sel       = 2'd1;
    crc_en_o      = 1'b0;
    crc_shift_o   = 1'b0;
    crc_clr_o     = 1'b0;
    status_we_o   = 1'b0;
    top_inhibit_o = 1'b0;

    case (state_q)
      st_idle: begin
        // Internal register access stays in idle
        out_shift = module_select_i & shift_dr_i;
        out_ld    = module_select_i & capture_dr_i;
        if (module_select_i && update_dr_i) begin
          regsel_ld   = intreg_cmd;
          status_we_o = intreg_cmd && (op_in == op_ireg_wr) && (regsel_in == '0);
          if (burst_cmd) begin
            state_d   = (op_in == op_bread32) ? st_rbegin : st_wready;
            addr_ld   = 1'b1;
            op_ld     = 1'b1;
            bit_rst   = 1'b1;
            word_ld   = 1'b1;
            crc_clr_o = 1'b1;
          end
        end
      end
      st_rbegin: begin
        if (word_zero) begin
          state_d = st_idle;  // Empty burst
        end else begin
          state_d  = st_rready;
          strobe   = 1'b1;    // Fetch the first word early
          addr_inc = 1'b1;
        end
      end
      st_rready: begin
        if (module_select_i && capture_dr_i) state_d = st_rstatus;
      end
      st_rstatus: begin
        tdo_sel       = 2'd0;
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = st_idle;
        end else if (bus_if.rdy) begin
          state_d     = st_rburst;
          out_ld      = 1'b1;
          out_sel_bus = 1'b1;
          bit_rst     = 1'b1;
          word_dec    = 1'b1;
          strobe      = (word_cnt_dec != '0);
          addr_inc    = (word_cnt_dec != '0);
        end
      end
      st_rburst: begin
        out_shift     = 1'b1;
        bit_en        = 1'b1;
        crc_en_o      = 1'b1;  // CRC sees the bit on TDO
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = st_idle;
        end else if (bit_max && word_zero) begin
          state_d = st_rcrc;
        end else if (bit_max) begin
          // Next word back to back, its fetch is long done
          out_ld      = 1'b1;
          out_sel_bus = 1'b1;
          bit_rst     = 1'b1;
          word_dec    = 1'b1;
          strobe      = (word_cnt_dec != '0);
          addr_inc    = (word_cnt_dec != '0);
        end
      end
      st_rcrc: begin
        tdo_sel       = 2'd3;
        crc_shift_o   = 1'b1;
        top_inhibit_o = 1'b1;
        if (update_dr_i) state_d = st_idle;
      end
      st_wready: begin
        if (word_zero) begin
          state_d = st_idle;
        end else if (module_select_i && capture_dr_i) begin
          state_d = st_wwait;
        end
      end
      st_wwait: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = st_idle;
        end else if (module_select_i && data_register_i[`DBG_DR_W-1]) begin
          state_d  = st_wburst;  // Start bit seen, first data bit on tdi_i
          bit_en   = 1'b1;
          word_dec = 1'b1;
          crc_en_o = 1'b1;
        end
      end
      st_wburst: begin
        bit_en        = 1'b1;
        crc_en_o      = 1'b1;
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = st_idle;
        end else if (bit_max) begin
          bit_rst  = 1'b1;
          strobe   = 1'b1;  // Word complete this cycle
          addr_inc = 1'b1;
          word_dec = 1'b1;
          if (word_zero) state_d = st_wcrc;
        end
      end
      st_wcrc: begin
        bit_en        = 1'b1;
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_d = st_idle;
        end else if (bit_32) begin
          state_d = st_wmatch;
          tdo_sel = 2'd2;
        end
      end
      st_wmatch: begin
        tdo_sel       = 2'd2;
        top_inhibit_o = 1'b1;
        if (update_dr_i) state_d = st_idle;
      end
      default: state_d = st_idle;
    endcase
  end

endmodule

// ==== hdl/dbg_cpu_module.sv ====
`timescale 1ns/1ps
`include "dbg_cpu_params.svh"

module dbg_cpu_module (
  input  logic                   tck_i,
  input  logic                   rst_i,
  // TAP side
  input  logic                   capture_dr_i,
  input  logic                   shift_dr_i,
  input  logic                   update_dr_i,
  input  logic                   module_select_i,
  input  logic                   tdi_i,
  input  logic [`DBG_DR_W-1:0]   data_register_i,
  output logic                   module_tdo_o,
  output logic                   top_inhibit_o,
  // SPR bus side
  output logic [`DBG_WORD_W-1:0] cpu_addr_o,
  output logic [`DBG_WORD_W-1:0] cpu_data_o,
  input  logic [`DBG_WORD_W-1:0] cpu_data_i,
  output logic                   cpu_stb_o,
  output logic                   cpu_we_o,
  input  logic                   cpu_ack_i,
  output logic                   cpu_stall_o,
  output logic                   cpu_rst_o,
  input  logic                   cpu_bp_i
);

  logic [`DBG_WORD_W-1:0] crc;
  logic                   crc_serial;
  logic                   crc_data;
  logic                   crc_en;
  logic                   crc_shift;
  logic                   crc_clr;
  logic [1:0]             status;
  logic                   status_we;

  dbg_cpu_bus_if bus_if ();

  ////////////////////////////////////////////////////////////////////////////
  // Control, bus bridge, CRC and status register

  dbg_cpu_burst_ctrl burst_ctrl_i (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tdi_i           (tdi_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .module_select_i (module_select_i),
    .data_register_i (data_register_i),
    .bus_if          (bus_if.ctrl),
    .crc_o           (crc),
    .crc_serial_i    (crc_serial),
    .crc_data_o      (crc_data),
    .crc_en_o        (crc_en),
    .crc_shift_o     (crc_shift),
    .crc_clr_o       (crc_clr),
    .status_i        (status),
    .status_we_o     (status_we),
    .module_tdo_o    (module_tdo_o),
    .top_inhibit_o   (top_inhibit_o)
  );

  dbg_cpu_spr_bridge spr_bridge_i (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .bus_if     (bus_if.bridge),
    .cpu_addr_o (cpu_addr_o),
    .cpu_data_o (cpu_data_o),
    .cpu_data_i (cpu_data_i),
    .cpu_stb_o  (cpu_stb_o),
    .cpu_we_o   (cpu_we_o),
    .cpu_ack_i  (cpu_ack_i)
  );

  dbg_cpu_crc32 crc32_i (
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .data_i   (crc_data),
    .enable_i (crc_en),
    .shift_i  (crc_shift),
    .clr_i    (crc_clr),
    .crc_o    (crc),
    .serial_o (crc_serial)
  );

  // Stall and reset bits sit just below the register select
  dbg_cpu_status_reg status_reg_i (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .we_i        (status_we),
    .data_i      (data_register_i[`DBG_ADDR_HI-`DBG_REGSEL_W -: 2]),
    .bp_i        (cpu_bp_i),
    .ctrl_reg_o  (status),
    .cpu_stall_o (cpu_stall_o),
    .cpu_rst_o   (cpu_rst_o)
  );

endmodule

// ==== verification/dbg_cpu_module_checker.sv ====
`timescale 1ns/1ps

// SPR bus protocol and reset state rules
module dbg_cpu_module_checker (
  input logic        tck_i,
  input logic        rst_i,
  input logic        cpu_stb_o,
  input logic        cpu_we_o,
  input logic        cpu_ack_i,
  input logic        cpu_stall_o,
  input logic        cpu_rst_o,
  input logic        top_inhibit_o,
  input logic [31:0] cpu_addr_o,
  input logic [31:0] cpu_data_o
);

  int fail_cnt = 0;  // Failed assertions so far

  // Strobe stays up until the access is acknowledged
  stb_hold: assert property (@(posedge tck_i) disable iff (rst_i)
    cpu_stb_o && !cpu_ack_i |=> cpu_stb_o)
    else begin
      fail_cnt++;
      $error("cpu_stb_o dropped before cpu_ack_i");
    end

  // Address and data frozen during an access
  bus_stable: assert property (@(posedge tck_i) disable iff (rst_i)
    cpu_stb_o && !cpu_ack_i |=> $stable(cpu_addr_o) && $stable(cpu_data_o))
    else begin
      fail_cnt++;
      $error("SPR address or data changed while cpu_stb_o was high");
    end

  reset_state: assert property (@(posedge tck_i)
    rst_i |-> !cpu_stb_o && !cpu_we_o && !cpu_stall_o && !cpu_rst_o && !top_inhibit_o)
    else begin
      fail_cnt++;
      $error("Outputs not low during reset");
    end

endmodule

bind dbg_cpu_module dbg_cpu_module_checker checker_i (
  .tck_i         (tck_i),
  .rst_i         (rst_i),
  .cpu_stb_o     (cpu_stb_o),
  .cpu_we_o      (cpu_we_o),
  .cpu_ack_i     (cpu_ack_i),
  .cpu_stall_o   (cpu_stall_o),
  .cpu_rst_o     (cpu_rst_o),
  .top_inhibit_o (top_inhibit_o),
  .cpu_addr_o    (cpu_addr_o),
  .cpu_data_o    (cpu_data_o)
);

// ==== verification/dbg_cpu_module_tb.sv ====
`timescale 1ns/1ps
`include "dbg_cpu_params.svh"

module dbg_cpu_module_tb;

  // Rough cycle budget of the five tests
  localparam int test_cycles = 20 + 320 + 320 + 600 + 400;
  localparam logic [15:0] lfsr_seed = 16'(74553);  // Seed cut to the LFSR width

  logic                 tck_i = 1'b0;
  logic                 rst_i;
  logic                 capture_dr_i, shift_dr_i, update_dr_i, module_select_i, tdi_i;
  logic [`DBG_DR_W-1:0] data_register_i;  // TAP shift register model
  logic                 module_tdo_o, top_inhibit_o;
  logic [31:0]          cpu_addr_o, cpu_data_o;
  logic [31:0]          cpu_data_i = '0;
  logic                 cpu_stb_o, cpu_we_o, cpu_stall_o, cpu_rst_o;
  logic                 cpu_ack_i = 1'b0;
  logic                 cpu_bp_i;

  logic [31:0] mem [0:255];  // SPR memory model
  logic        written [0:255];
  logic        busy = 1'b0;
  int          wait_cnt = 0;
  logic [15:0] mem_lfsr = lfsr_seed;
  logic [15:0] data_lfsr = lfsr_seed;
  string       cur_test;
  int          errors = 0;
  int          errs_before, tests_run = 0, tests_failed = 0;

  dbg_cpu_module dbg_cpu_module_i (.*);

  always #10 tck_i = ~tck_i;  // 20 ns period

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Reflected CRC-32, one bit, no final inversion
  function automatic logic [31:0] crc_bit(input logic [31:0] c, input logic b);
    crc_bit = (c >> 1) ^ ((c[0] ^ b) ? `DBG_CRC_POLY : 32'h0);
  endfunction

  function automatic logic [31:0] fill_word(input logic [7:0] a);
    fill_word = {a, ~a, a ^ 8'h5a, 8'hc3 ^ {a[3:0], a[7:4]}};
  endfunction

  // Memory acks each access after 1 to 3 cycles
  always @(posedge tck_i) begin
    logic [15:0] s;
    int          v;
    if (rst_i) begin
      for (int i = 0; i < 256; i++) begin
        mem[i]     <= fill_word(8'(i));
        written[i] <= 1'b0;
      end
      cpu_ack_i <= 1'b0;
      busy      <= 1'b0;
    end else if (cpu_ack_i) begin
      cpu_ack_i <= 1'b0;
      busy      <= 1'b0;
    end else if (cpu_stb_o && !busy) begin
      s        = lfsr_next(mem_lfsr);
      v        = s[0];
      s        = lfsr_next(s);
      v        = v + 2 * s[0];  // Two bits taken
      mem_lfsr <= s;
      busy     <= 1'b1;
      wait_cnt <= (v == 0) ? 1 : v;
    end else if (busy) begin
      if (wait_cnt <= 1) begin
        cpu_ack_i <= 1'b1;
        if (cpu_we_o) begin
          mem[cpu_addr_o[7:0]]     <= cpu_data_o;
          written[cpu_addr_o[7:0]] <= 1'b1;
        end else begin
          cpu_data_i <= mem[cpu_addr_o[7:0]];
        end
      end else begin
        wait_cnt <= wait_cnt - 1;
      end
    end
  end

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    errs_before = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors != errs_before) tests_failed++;
    $display("%s: %s", cur_test, (errors == errs_before) ? "passed" : "failed");
  endtask

  task automatic draw_word(output logic [31:0] w);
    for (int j = 0; j < 32; j++) begin
      data_lfsr = lfsr_next(data_lfsr);
      w[j]      = data_lfsr[0];
    end
  endtask

  // Load the TAP register and pulse update
  task automatic send_cmd(input logic [3:0] op, input logic [31:0] addr, input logic [15:0] cnt);
    data_register_i <= {1'b0, op, addr, cnt};
    shift_dr_i      <= 1'b0;
    update_dr_i     <= 1'b1;
    @(posedge tck_i);
    update_dr_i <= 1'b0;
  endtask

  task automatic capture();
    @(posedge tck_i);  // Select-DR-Scan lies between update and capture
    capture_dr_i <= 1'b1;
    @(posedge tck_i);
    capture_dr_i <= 1'b0;
  endtask

  // One shift cycle, TDO sampled on the shifting edge
  task automatic shift_bit(input logic b, output logic t);
    tdi_i      <= b;
    shift_dr_i <= 1'b1;
    @(posedge tck_i);
    t = module_tdo_o;
    data_register_i <= {b, data_register_i[`DBG_DR_W-1:1]};
  endtask

  task automatic end_burst();
    shift_dr_i  <= 1'b0;
    update_dr_i <= 1'b1;
    @(posedge tck_i);
    update_dr_i <= 1'b0;
    @(posedge tck_i);
  endtask

  task automatic write_status(input logic rst_b, input logic stall_b);
    send_cmd(`DBG_OP_IREG_WR, {1'b0, rst_b, stall_b, 29'h0}, 16'h0);
    @(posedge tck_i);
  endtask

  task automatic read_status(output logic [31:0] v);
    logic t;
    send_cmd(`DBG_OP_IREG_SEL, 32'h0, 16'h0);
    capture();
    for (int j = 0; j < 32; j++) begin
      shift_bit(1'b0, t);
      v[j] = t;
    end
    shift_dr_i <= 1'b0;
    @(posedge tck_i);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic test_reset();
    begin_test("reset");
    check_value("outputs", 5'b0, {cpu_stb_o, cpu_we_o, cpu_stall_o, cpu_rst_o, top_inhibit_o});
    end_test();
  endtask

  task automatic test_status();
    logic [31:0] v;
    begin_test("status");
    write_status(1'b1, 1'b1);
    check_value("stall and reset", 2'b11, {cpu_stall_o, cpu_rst_o});
    read_status(v);
    check_value("status read", 32'd3, v);
    write_status(1'b0, 1'b0);
    check_value("cleared outputs", 2'b00, {cpu_stall_o, cpu_rst_o});
    end_test();
  endtask

  task automatic test_breakpoint();
    logic [31:0] v;
    begin_test("breakpoint");
    cpu_bp_i <= 1'b1;
    @(posedge tck_i);
    cpu_bp_i <= 1'b0;
    repeat (2) @(posedge tck_i);
    check_value("stall after pulse", 1'b1, cpu_stall_o);
    read_status(v);
    check_value("status after pulse", 32'd1, v);
    write_status(1'b0, 1'b0);
    read_status(v);
    check_value("status cleared", 32'd0, v);
    check_value("stall cleared", 1'b0, cpu_stall_o);
    end_test();
  endtask

  // Four words, CRC optionally corrupted, returns the match bit
  task automatic write_burst(input logic [7:0] base, input logic bad, output logic match);
    logic [31:0] words [4];
    logic [31:0] crc;
    logic        t;
    crc = '1;
    for (int i = 0; i < 4; i++) begin
      draw_word(words[i]);
      for (int j = 0; j < 32; j++) crc = crc_bit(crc, words[i][j]);
    end
    if (bad) crc = crc ^ 32'h0000_0010;
    send_cmd(`DBG_OP_BWRITE32, {24'h0, base}, 16'd4);
    capture();
    shift_bit(1'b1, t);  // Start bit
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 32; j++) shift_bit(words[i][j], t);
    end
    for (int j = 0; j < 32; j++) shift_bit(crc[j], t);
    shift_dr_i <= 1'b0;
    @(posedge tck_i);
    match = module_tdo_o;
    end_burst();
    for (int i = 0; i < 4; i++) begin
      check_value("memory word", words[i], mem[base + 8'(i)]);
      check_value("write enable seen", 1'b1, written[base + 8'(i)]);
    end
  endtask

  task automatic test_burst_write();
    logic match;
    begin_test("burst_write");
    write_burst(8'h40, 1'b0, match);
    check_value("CRC match", 1'b1, match);
    write_burst(8'h50, 1'b1, match);
    check_value("CRC mismatch", 1'b0, match);
    end_test();
  endtask

  task automatic test_burst_read();
    logic [31:0] got, crc;
    logic        t;
    int          polls;
    begin_test("burst_read");
    crc = '1;
    send_cmd(`DBG_OP_BREAD32, 32'h80, 16'd3);
    capture();
    polls = 0;
    t     = 1'b0;
    while (!t && polls < 64) begin
      shift_bit(1'b0, t);
      check_value("inhibit while polling", 1'b1, top_inhibit_o);
      polls++;
    end
    if (!t) begin
      $display("%s: ready bit never read as 1 after %0d polls", cur_test, polls);
      errors++;
    end
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 32; j++) begin
        shift_bit(1'b0, t);
        got[j] = t;
        crc    = crc_bit(crc, t);
        check_value("inhibit during data", 1'b1, top_inhibit_o);
      end
      check_value("read word", fill_word(8'h80 + 8'(i)), got);
    end
    for (int j = 0; j < 32; j++) begin
      shift_bit(1'b0, t);
      got[j] = t;
    end
    check_value("read CRC", crc, got);
    check_value("inhibit in CRC", 1'b1, top_inhibit_o);
    end_burst();
    end_test();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog

  initial begin
    rst_i           = 1'b1;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    module_select_i = 1'b1;  // This module always selected
    tdi_i           = 1'b0;
    data_register_i = '0;
    cpu_bp_i        = 1'b0;
    repeat (8) @(posedge tck_i);
    rst_i <= 1'b0;
    repeat (2) @(posedge tck_i);
    test_reset();
    test_status();
    test_breakpoint();
    test_burst_write();
    test_burst_read();
    errors = errors + dbg_cpu_module_i.checker_i.fail_cnt;
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(2 * test_cycles * 20);
    $display("Watchdog expired before the tests finished");
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== dbg_cpu_module.f ====
+incdir+hdl
hdl/dbg_cpu_pkg.sv
hdl/dbg_cpu_bus_if.sv
hdl/dbg_cpu_spr_bridge.sv
hdl/dbg_cpu_crc32.sv
hdl/dbg_cpu_status_reg.sv
hdl/dbg_cpu_burst_ctrl.sv
hdl/dbg_cpu_module.sv
verification/dbg_cpu_module_checker.sv
verification/dbg_cpu_module_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := dbg_cpu_module_tb
FILELIST  := dbg_cpu_module.f
LOG       := sim.log
OBJDIR    := obj_dir

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
